// File: muldiv_params.svh
// muldiv unit parameters

`ifndef MULDIV_PARAMS_SVH
`define MULDIV_PARAMS_SVH

// transaction id width, shared by the whole unit
`define MULDIV_ID_W 5

// operand and result width
`define MULDIV_XLEN 32

////////////////////
// RISC-V opcode fields
////////////////////

// major opcode of register-register operations
`define MULDIV_OPCODE_OP 7'b0110011
// funct7 that marks the M extension
`define MULDIV_FUNCT7_M 7'b0000001

`endif

// File: muldiv_pkg.sv
// muldiv shared types

`include "muldiv_params.svh"

package muldiv_pkg;

  // raw instruction word
  typedef logic [31:0] instr_t;

  // operand or result
  typedef logic [`MULDIV_XLEN-1:0] xlen_t;

  // transaction id
  typedef logic [`MULDIV_ID_W-1:0] trans_id_t;

  // operation selector, 0..3 multiply and 4..7 divide
  typedef logic [2:0] funct3_t;

  localparam funct3_t F3_MUL    = 3'd0;
  localparam funct3_t F3_MULH   = 3'd1;
  localparam funct3_t F3_MULHSU = 3'd2;
  localparam funct3_t F3_MULHU  = 3'd3;
  localparam funct3_t F3_DIV    = 3'd4;
  localparam funct3_t F3_DIVU   = 3'd5;
  localparam funct3_t F3_REM    = 3'd6;
  localparam funct3_t F3_REMU   = 3'd7;

  // serial divider FSM
  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_DONE
  } div_state_e;

endpackage

// File: muldiv_decode.sv
// muldiv request decoder

`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_decode
  import muldiv_pkg::*;
(
  input  instr_t  req_instr_i,
  input  logic    req_valid_i,
  input  logic    mul_ready_i,
  input  logic    div_ready_i,
  input  logic    err_ready_i,
  output logic    req_ready_o,
  output logic    mul_valid_o,
  output logic    div_valid_o,
  output logic    err_valid_o,
  output funct3_t funct3_o
);

  logic is_m_ext;
  logic is_div_grp;

  // M extension: OP opcode with funct7 0000001
  assign is_m_ext = (req_instr_i[6:0] == `MULDIV_OPCODE_OP) &&
                    (req_instr_i[31:25] == `MULDIV_FUNCT7_M);

  assign funct3_o   = req_instr_i[14:12];
  // funct3[2] splits multiply from divide
  assign is_div_grp = funct3_o[2];

  ////////////////////
  // request steering
  ////////////////////

  always_comb begin
    mul_valid_o = 1'b0;
    div_valid_o = 1'b0;
    err_valid_o = 1'b0;
    req_ready_o = 1'b0;
    if (is_m_ext && !is_div_grp) begin
      mul_valid_o = req_valid_i;
      req_ready_o = mul_ready_i;
    end else if (is_m_ext) begin
      div_valid_o = req_valid_i;
      req_ready_o = div_ready_i;
    end else begin
      // anything else goes to the error path
      err_valid_o = req_valid_i;
      req_ready_o = err_ready_i;
    end
  end

endmodule

// File: muldiv_mul.sv
// pipelined multiplier

`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_mul
  import muldiv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  funct3_t   funct3_i,
  input  xlen_t     a_i,
  input  xlen_t     b_i,
  input  trans_id_t id_i,
  input  logic      ready_i,
  output logic      ready_o,
  output logic      valid_o,
  output xlen_t     result_o,
  output trans_id_t id_o
);

  localparam int XLEN = `MULDIV_XLEN;

  logic                       sign_a;
  logic                       sign_b;
  logic                       upper_d;
  logic                       upper_q;
  logic                       load;
  logic                       valid_q;
  logic signed [2*XLEN-1:0]   a_ext;
  logic signed [2*XLEN-1:0]   b_ext;
  logic signed [2*XLEN-1:0]   prod_d;
  logic        [2*XLEN-1:0]   prod_q;
  trans_id_t                  id_q;

  // sign selection per variant
  always_comb begin
    sign_a  = 1'b0;
    sign_b  = 1'b0;
    upper_d = 1'b1;
    unique case (funct3_i)
      F3_MULH: begin
        sign_a = 1'b1;
        sign_b = 1'b1;
      end
      F3_MULHSU: sign_a = 1'b1;
      F3_MULHU:  upper_d = 1'b1;
      // plain MUL keeps the low half
      F3_MUL:    upper_d = 1'b0;
      default:   upper_d = 1'b0;
    endcase
  end

  // operands extended signed or unsigned, product low 64 bits are exact
  assign a_ext  = {{XLEN{sign_a & a_i[XLEN-1]}}, a_i};
  assign b_ext  = {{XLEN{sign_b & b_i[XLEN-1]}}, b_i};
  assign prod_d = a_ext * b_ext;

  // new request may enter while the old result drains
  assign ready_o = ~valid_q | ready_i;
  assign load    = valid_i & ready_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  ////////////////////
  // pipeline register
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      prod_q  <= prod_d;
      upper_q <= upper_d;
      id_q    <= id_i;
    end
  end

  assign valid_o  = valid_q;
  assign id_o     = id_q;
  assign result_o = upper_q ? prod_q[2*XLEN-1:XLEN] : prod_q[XLEN-1:0];

endmodule

// File: muldiv_div.sv
// serial divider

`timescale 1ns/1ps
`include "muldiv_params.svh"

module muldiv_div
  import muldiv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  funct3_t   funct3_i,
  input  xlen_t     a_i,
  input  xlen_t     b_i,
  input  trans_id_t id_i,
  input  logic      ready_i,
  output logic      ready_o,
  output logic      valid_o,
  output xlen_t     result_o,
  output trans_id_t id_o
);

  localparam int XLEN = `MULDIV_XLEN;
  localparam int CntW = $clog2(XLEN + 1);

  div_state_e      state_d;
  div_state_e      state_q;
  logic            signed_op;
  logic            rem_op;
  logic            a_neg;
  logic            b_neg;
  logic            b_zero;
  logic            early;
  logic            load;
  logic            r_ge;
  xlen_t           a_abs;
  xlen_t           b_abs;
  xlen_t           r_q;
  xlen_t           d_q;
  xlen_t           q_q;
  xlen_t           quo_fix;
  xlen_t           rem_fix;
  logic [CntW-1:0] lz_a;
  logic [CntW-1:0] lz_b;
  logic [CntW-1:0] shift;
  logic [CntW-1:0] cnt_q;
  logic            rem_sel_q;
  logic            neg_quo_q;
  logic            neg_rem_q;
  trans_id_t       id_q;

  // number of leading zeros, XLEN for a zero word
  function automatic logic [CntW-1:0] clz(input xlen_t v);
    logic [CntW-1:0] n;
    logic            found;
    n     = CntW'(XLEN);
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (!found && v[i]) begin
        n     = CntW'(XLEN - 1 - i);
        found = 1'b1;
      end
    end
    return n;
  endfunction

  ////////////////////
  // operand alignment
  ////////////////////

  assign signed_op = (funct3_i == F3_DIV) || (funct3_i == F3_REM);
  assign rem_op    = (funct3_i == F3_REM) || (funct3_i == F3_REMU);
  assign a_neg     = signed_op & a_i[XLEN-1];
  assign b_neg     = signed_op & b_i[XLEN-1];
  assign a_abs     = a_neg ? -a_i : a_i;
  assign b_abs     = b_neg ? -b_i : b_i;
  assign b_zero    = (b_i == '0);
  assign lz_a      = clz(a_abs);
  assign lz_b      = clz(b_abs);
  // divisor has more significant bits than the dividend, quotient is 0
  assign early     = lz_b < lz_a;
  assign shift     = lz_b - lz_a;

  assign ready_o = (state_q == DIV_IDLE);
  assign valid_o = (state_q == DIV_DONE);
  assign load    = valid_i & ready_o;
  assign r_ge    = (r_q >= d_q);

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      DIV_IDLE: begin
        if (valid_i) begin
          state_d = (b_zero || early) ? DIV_DONE : DIV_RUN;
        end
      end
      DIV_RUN:  if (cnt_q == '0) state_d = DIV_DONE;
      DIV_DONE: if (ready_i) state_d = DIV_IDLE;
      default:  state_d = DIV_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= DIV_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        cnt_q <= shift;
      end else if (state_q == DIV_RUN && cnt_q != '0) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  ////////////////////
  // datapath
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      id_q      <= id_i;
      rem_sel_q <= rem_op;
      neg_quo_q <= ~b_zero & (a_neg ^ b_neg);
      neg_rem_q <= a_neg;
      r_q       <= a_abs;
      d_q       <= b_abs << shift;
      // divide by zero answers all ones
      q_q       <= b_zero ? '1 : '0;
    end else if (state_q == DIV_RUN) begin
      // one quotient bit per cycle
      if (r_ge) begin
        r_q <= r_q - d_q;
      end
      q_q <= {q_q[XLEN-2:0], r_ge};
      d_q <= d_q >> 1;
    end
  end

  // quotient truncates toward zero, remainder follows the dividend sign
  assign quo_fix  = neg_quo_q ? -q_q : q_q;
  assign rem_fix  = neg_rem_q ? -r_q : r_q;
  assign result_o = rem_sel_q ? rem_fix : quo_fix;
  assign id_o     = id_q;

endmodule

// File: muldiv_result.sv
// muldiv result arbiter

`timescale 1ns/1ps

module muldiv_result
  import muldiv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      mul_valid_i,
  input  xlen_t     mul_result_i,
  input  trans_id_t mul_id_i,
  input  logic      div_valid_i,
  input  xlen_t     div_result_i,
  input  trans_id_t div_id_i,
  input  logic      err_valid_i,
  input  trans_id_t req_id_i,
  input  logic      rsp_ready_i,
  output logic      mul_ready_o,
  output logic      div_ready_o,
  output logic      err_ready_o,
  output xlen_t     rsp_data_o,
  output trans_id_t rsp_id_o,
  output logic      rsp_error_o,
  output logic      rsp_valid_o
);

  logic       err_valid_q;
  trans_id_t  err_id_q;
  logic       err_take;
  logic       err_fire;
  logic [2:0] src_valid;
  logic [1:0] grant;
  logic [1:0] grant_q;
  logic [1:0] last_q;
  logic [1:0] cand_1;
  logic [1:0] cand_2;
  logic       lock_q;

  function automatic logic [1:0] next_src(input logic [1:0] idx);
    return (idx == 2'd2) ? 2'd0 : idx + 2'd1;
  endfunction

  // error entry, drains and refills in one cycle
  assign err_fire    = err_take & err_valid_q;
  assign err_ready_o = ~err_valid_q | err_fire;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_valid_q <= 1'b0;
    end else if (err_valid_i && err_ready_o) begin
      err_valid_q <= 1'b1;
    end else if (err_fire) begin
      err_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (err_valid_i && err_ready_o) begin
      err_id_q <= req_id_i;
    end
  end

  ////////////////////
  // round-robin grant
  ////////////////////

  // source 0 mul, 1 div, 2 error
  assign src_valid = {err_valid_q, div_valid_i, mul_valid_i};
  assign cand_1    = next_src(last_q);
  assign cand_2    = next_src(cand_1);

  always_comb begin
    if (lock_q) begin
      grant = grant_q;
    end else if (src_valid[cand_1]) begin
      grant = cand_1;
    end else if (src_valid[cand_2]) begin
      grant = cand_2;
    end else begin
      grant = last_q;
    end
  end

  always_comb begin
    rsp_valid_o = 1'b0;
    rsp_data_o  = '0;
    rsp_id_o    = '0;
    rsp_error_o = 1'b0;
    mul_ready_o = 1'b0;
    div_ready_o = 1'b0;
    err_take    = 1'b0;
    unique case (grant)
      2'd0: begin
        rsp_valid_o = mul_valid_i;
        rsp_data_o  = mul_result_i;
        rsp_id_o    = mul_id_i;
        mul_ready_o = rsp_ready_i;
      end
      2'd1: begin
        rsp_valid_o = div_valid_i;
        rsp_data_o  = div_result_i;
        rsp_id_o    = div_id_i;
        div_ready_o = rsp_ready_i;
      end
      default: begin
        // illegal instruction reply, data stays 0
        rsp_valid_o = err_valid_q;
        rsp_id_o    = err_id_q;
        rsp_error_o = 1'b1;
        err_take    = rsp_ready_i;
      end
    endcase
  end

  // grant is frozen while a response is stalled
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lock_q  <= 1'b0;
      grant_q <= 2'd0;
      last_q  <= 2'd2;
    end else if (rsp_valid_o && rsp_ready_i) begin
      lock_q <= 1'b0;
      last_q <= grant;
    end else if (rsp_valid_o) begin
      lock_q  <= 1'b1;
      grant_q <= grant;
    end
  end

endmodule

// File: muldiv_unit.sv
// shared M-extension unit

`timescale 1ns/1ps

module muldiv_unit
  import muldiv_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // request port
  input  instr_t    req_instr_i,
  input  xlen_t     req_a_i,
  input  xlen_t     req_b_i,
  input  trans_id_t req_id_i,
  input  logic      req_valid_i,
  output logic      req_ready_o,
  // response port
  output xlen_t     rsp_data_o,
  output trans_id_t rsp_id_o,
  output logic      rsp_error_o,
  output logic      rsp_valid_o,
  input  logic      rsp_ready_i
);

  // decode to execute handshakes
  logic      mul_in_valid;
  logic      mul_in_ready;
  logic      div_in_valid;
  logic      div_in_ready;
  logic      err_in_valid;
  logic      err_in_ready;
  funct3_t   funct3;

  // execute to result stage
  logic      mul_out_valid;
  logic      mul_out_ready;
  xlen_t     mul_out_result;
  trans_id_t mul_out_id;
  logic      div_out_valid;
  logic      div_out_ready;
  xlen_t     div_out_result;
  trans_id_t div_out_id;

  muldiv_decode u_decode (
    .req_instr_i (req_instr_i),
    .req_valid_i (req_valid_i),
    .mul_ready_i (mul_in_ready),
    .div_ready_i (div_in_ready),
    .err_ready_i (err_in_ready),
    .req_ready_o (req_ready_o),
    .mul_valid_o (mul_in_valid),
    .div_valid_o (div_in_valid),
    .err_valid_o (err_in_valid),
    .funct3_o    (funct3)
  );

  muldiv_mul u_mul (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (mul_in_valid),
    .funct3_i (funct3),
    .a_i      (req_a_i),
    .b_i      (req_b_i),
    .id_i     (req_id_i),
    .ready_i  (mul_out_ready),
    .ready_o  (mul_in_ready),
    .valid_o  (mul_out_valid),
    .result_o (mul_out_result),
    .id_o     (mul_out_id)
  );

  muldiv_div u_div (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .valid_i  (div_in_valid),
    .funct3_i (funct3),
    .a_i      (req_a_i),
    .b_i      (req_b_i),
    .id_i     (req_id_i),
    .ready_i  (div_out_ready),
    .ready_o  (div_in_ready),
    .valid_o  (div_out_valid),
    .result_o (div_out_result),
    .id_o     (div_out_id)
  );

  muldiv_result u_result (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .mul_valid_i  (mul_out_valid),
    .mul_result_i (mul_out_result),
    .mul_id_i     (mul_out_id),
    .div_valid_i  (div_out_valid),
    .div_result_i (div_out_result),
    .div_id_i     (div_out_id),
    .err_valid_i  (err_in_valid),
    .req_id_i     (req_id_i),
    .rsp_ready_i  (rsp_ready_i),
    .mul_ready_o  (mul_out_ready),
    .div_ready_o  (div_out_ready),
    .err_ready_o  (err_in_ready),
    .rsp_data_o   (rsp_data_o),
    .rsp_id_o     (rsp_id_o),
    .rsp_error_o  (rsp_error_o),
    .rsp_valid_o  (rsp_valid_o)
  );

endmodule

// File: tb_muldiv_chk.sv
// muldiv handshake checks

`timescale 1ns/1ps
`include "muldiv_params.svh"

module tb_muldiv_chk
  import muldiv_pkg::*;
(
  input logic      clk_i,
  input logic      rst_ni,
  input instr_t    req_instr_i,
  input logic      req_valid_i,
  input logic      req_ready_i,
  input xlen_t     rsp_data_i,
  input trans_id_t rsp_id_i,
  input logic      rsp_error_i,
  input logic      rsp_valid_i,
  input logic      rsp_ready_i
);

  logic illegal;
  logic err_pend_q;
  logic err_room;

  // anything outside OP with the M funct7
  assign illegal = !((req_instr_i[6:0] == `MULDIV_OPCODE_OP) &&
                     (req_instr_i[31:25] == `MULDIV_FUNCT7_M));

  // illegal request taken and not yet answered
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      err_pend_q <= 1'b0;
    end else if (req_valid_i && req_ready_i && illegal) begin
      err_pend_q <= 1'b1;
    end else if (rsp_valid_i && rsp_ready_i && rsp_error_i) begin
      err_pend_q <= 1'b0;
    end
  end

  // error reply slot empty or draining now
  assign err_room = !err_pend_q || (rsp_valid_i && rsp_ready_i && rsp_error_i);

  // stalled response keeps valid and payload
  rsp_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rsp_valid_i && !rsp_ready_i |=> rsp_valid_i && $stable(rsp_data_i) &&
                                    $stable(rsp_id_i) && $stable(rsp_error_i))
    else $error("response dropped or changed while stalled");

  rsp_reset_a: assert property (@(posedge clk_i) !rst_ni |-> !rsp_valid_i)
    else $error("response valid during reset");

  // error entry free, illegal request must be taken
  err_accept_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_valid_i && illegal && err_room |-> req_ready_i)
    else $error("illegal request refused while the error entry was free");

endmodule

// File: tb_muldiv.sv
// muldiv unit testbench

`timescale 1ns/1ps
`include "muldiv_params.svh"

module tb_muldiv
  import muldiv_pkg::*;
();

  localparam int    MaxEntries     = 2 ** `MULDIV_ID_W;
  localparam int    CyclesPerEntry = 80;
  localparam int    ResetCycles    = 16;
  localparam string GoldenFile     = "muldiv_golden.txt";

  logic      clk       = 1'b0;
  logic      rst_n     = 1'b0;
  instr_t    req_instr = '0;
  xlen_t     req_a     = '0;
  xlen_t     req_b     = '0;
  trans_id_t req_id    = '0;
  logic      req_valid = 1'b0;
  logic      req_ready;
  xlen_t     rsp_data;
  trans_id_t rsp_id;
  logic      rsp_error;
  logic      rsp_valid;
  logic      rsp_ready = 1'b0;

  // golden table, one slot per entry
  instr_t    g_instr [MaxEntries];
  xlen_t     g_a     [MaxEntries];
  xlen_t     g_b     [MaxEntries];
  trans_id_t g_id    [MaxEntries];
  xlen_t     g_data  [MaxEntries];
  logic      g_err   [MaxEntries];
  int        entry_of_id [MaxEntries];
  bit        seen    [MaxEntries];

  int          n_entries    = 0;
  int          cycle_limit  = 0;
  int          cycle_cnt    = 0;
  int          n_rsp        = 0;
  int          n_pass       = 0;
  int          n_bad        = 0;
  int          n_overtake   = 0;
  int          max_idx_seen = -1;
  logic [31:0] rand_q       = 32'h4c4e978f;

  muldiv_unit u_muldiv_unit (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_instr_i (req_instr),
    .req_a_i     (req_a),
    .req_b_i     (req_b),
    .req_id_i    (req_id),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .rsp_data_o  (rsp_data),
    .rsp_id_o    (rsp_id),
    .rsp_error_o (rsp_error),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready)
  );

  bind muldiv_unit tb_muldiv_chk u_chk (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_instr_i (req_instr_i),
    .req_valid_i (req_valid_i),
    .req_ready_i (req_ready_o),
    .rsp_data_i  (rsp_data_o),
    .rsp_id_i    (rsp_id_o),
    .rsp_error_i (rsp_error_o),
    .rsp_valid_i (rsp_valid_o),
    .rsp_ready_i (rsp_ready_i)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  function automatic logic [31:0] next_rand(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // response port stalls about one cycle in four
  always @(posedge clk) begin
    rand_q    <= next_rand(rand_q);
    rsp_ready <= rst_n && (rand_q[31:30] != 2'b00);
  end

  // mnemonic from the RISC-V encoding
  function automatic string op_name(input instr_t instr);
    if (instr[6:0] != `MULDIV_OPCODE_OP || instr[31:25] != `MULDIV_FUNCT7_M) begin
      return "illegal";
    end
    case (instr[14:12])
      3'd0:    return "mul";
      3'd1:    return "mulh";
      3'd2:    return "mulhsu";
      3'd3:    return "mulhu";
      3'd4:    return "div";
      3'd5:    return "divu";
      3'd6:    return "rem";
      default: return "remu";
    endcase
  endfunction

  task automatic check_response(input trans_id_t id, input xlen_t data, input logic err);
    int idx;
    idx = entry_of_id[id];
    if (idx < 0) begin
      $display("response with id %0d that no request carried", id);
      n_bad++;
    end else if (seen[idx]) begin
      $display("second response for id %0d", id);
      n_bad++;
    end else begin
      seen[idx] = 1'b1;
      n_rsp++;
      // a later request answered first
      if (idx < max_idx_seen) begin
        n_overtake++;
      end else begin
        max_idx_seen = idx;
      end
      if (data !== g_data[idx] || err !== g_err[idx]) begin
        $display("Fail %s id %0d: expected data %h error %0d, actual data %h error %0d",
                 op_name(g_instr[idx]), id, g_data[idx], g_err[idx], data, err);
        n_bad++;
      end else begin
        $display("ok   %s id %0d: data %h error %0d", op_name(g_instr[idx]), id, data, err);
        n_pass++;
      end
    end
  endtask

  // responses transfer on the next rising edge
  always @(negedge clk) begin
    if (rst_n && rsp_valid && rsp_ready) begin
      check_response(rsp_id, rsp_data, rsp_error);
    end
  end

  task automatic send_request(input int idx);
    req_instr <= g_instr[idx];
    req_a     <= g_a[idx];
    req_b     <= g_b[idx];
    req_id    <= g_id[idx];
    req_valid <= 1'b1;
    // hold until the unit takes it
    @(negedge clk);
    while (!req_ready) begin
      @(negedge clk);
    end
    @(posedge clk);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin : main
    int          fd;
    int          code;
    int          other_err;
    string       line;
    logic [31:0] f_instr;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_id;
    logic [31:0] f_data;
    logic [31:0] f_err;
    other_err = 0;
    foreach (entry_of_id[k]) begin
      entry_of_id[k] = -1;
    end
    fd = $fopen(GoldenFile, "r");
    if (fd == 0) begin
      $display("could not open %s", GoldenFile);
      other_err++;
    end else begin
      while ($fgets(line, fd) > 0) begin
        code = $sscanf(line, "%h %h %h %h %h %h", f_instr, f_a, f_b, f_id, f_data, f_err);
        // comment and blank lines do not parse
        if (code == 6) begin
          if (n_entries == MaxEntries) begin
            $display("golden file holds more entries than there are ids");
            other_err++;
          end else if (entry_of_id[f_id[`MULDIV_ID_W-1:0]] >= 0) begin
            $display("golden file uses id %0d more than once", f_id);
            other_err++;
          end else begin
            g_instr[n_entries] = f_instr;
            g_a[n_entries]     = f_a;
            g_b[n_entries]     = f_b;
            g_id[n_entries]    = f_id[`MULDIV_ID_W-1:0];
            g_data[n_entries]  = f_data;
            g_err[n_entries]   = f_err[0];
            entry_of_id[f_id[`MULDIV_ID_W-1:0]] = n_entries;
            n_entries++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_entries == 0) begin
      $display("golden file gave no requests");
      other_err++;
    end

    if (other_err == 0) begin
      cycle_limit = n_entries * CyclesPerEntry;
      repeat (ResetCycles) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      for (int i = 0; i < n_entries; i++) begin
        send_request(i);
      end
      req_valid <= 1'b0;
      wait (n_rsp == n_entries);
      // idle tail so a late duplicate still shows
      repeat (8) @(posedge clk);
      if (n_overtake == 0) begin
        $display("no response came back ahead of an earlier request");
        other_err++;
      end
    end

    $display("tests %0d, passed %0d, failed %0d, other errors %0d",
             n_entries, n_pass, n_bad, other_err);
    if (other_err == 0 && n_bad == 0 && n_pass == n_entries) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // hang guard
  initial begin : watchdog
    wait (cycle_limit > 0);
    wait (cycle_cnt >= cycle_limit);
    $display("timeout after %0d cycles with %0d of %0d responses",
             cycle_cnt, n_rsp, n_entries);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: muldiv_golden.txt
# one request per line, all fields hex
# instr a b id expected_data expected_error
0220d1b3 ffffffff 00000001 00 ffffffff 0
022081b3 00000007 00000006 01 0000002a 0
022081b3 ffffffff 00000005 02 fffffffb 0
022091b3 ffffffff 00000005 03 ffffffff 0
0220b1b3 ffffffff ffffffff 04 fffffffe 0
0220a1b3 ffffffff ffffffff 05 ffffffff 0
002081b3 12345678 9abcdef0 06 00000000 1
022091b3 80000000 80000000 07 40000000 0
022081b3 80000000 80000000 08 00000000 0
0220a1b3 80000000 80000000 09 c0000000 0
022091b3 7fffffff 80000000 0a c0000000 0
022081b3 12345678 00000010 0b 23456780 0
0220c1b3 ffffffec 00000006 0c fffffffd 0
0220e1b3 ffffffec 00000006 0d fffffffe 0
0220c1b3 00000014 fffffffa 0e fffffffd 0
0220e1b3 00000014 fffffffa 0f 00000002 0
0220c1b3 80000000 ffffffff 10 80000000 0
0220e1b3 80000000 ffffffff 11 00000000 0
0220d1b3 00000064 00000000 12 ffffffff 0
0220f1b3 00000064 00000000 13 00000064 0
0220e1b3 fffffff9 00000000 14 fffffff9 0
0220d1b3 00000005 00000009 15 00000000 0
0220f1b3 00000005 00000009 16 00000005 0
0220d1b3 fffffffe 00000003 17 55555554 0
0220f1b3 fffffffe 00000003 18 00000002 0
402081b3 00000001 00000002 19 00000000 1
022081bb 00000003 00000004 1a 00000000 1
0220c1b3 00000000 00000007 1b 00000000 0

// File: run.sh
#!/bin/sh
# build and run the muldiv regression with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_muldiv -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_muldiv)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q "^Regression passed$"; then
  exit 0
fi
echo "pass message not found"
exit 1

// File: flist.f
+incdir+.
muldiv_pkg.sv
muldiv_decode.sv
muldiv_mul.sv
muldiv_div.sv
muldiv_result.sv
muldiv_unit.sv
tb_muldiv_chk.sv
tb_muldiv.sv
